/* design/fog_pkg.sv */
package fog_pkg;

	// Every setting, error, step and ramp value is carried in this word
	typedef logic signed [31:0] word_t;

	localparam int ADC_W_DEF = 14; // Raw ADC sample width
	localparam int DAC_W_DEF = 16; // DAC code width

	// Register indices on the write port
	typedef enum logic [3:0] {
		REG_FREQ_CNT   = 4'd0,  // Half-period length in cycles
		REG_AMP_H      = 4'd1,  // High modulation level
		REG_AMP_L      = 4'd2,  // Low modulation level
		REG_POLARITY   = 4'd3,  // Error sign flip
		REG_WAIT_CNT   = 4'd4,  // Settling cycles per half
		REG_ERR_OFFSET = 4'd5,
		REG_CONST_STEP = 4'd6,  // Open-loop step
		REG_FB_ON      = 4'd7,  // Closed-loop enable
		REG_GAIN_SEL   = 4'd8,  // Error right shift
		REG_RUN        = 4'd9   // Modulation enable
	} fog_reg_e;

	// Which half of the square wave is being driven
	typedef enum logic {
		HALF_H = 1'b0,
		HALF_L = 1'b1
	} half_e;

	// Loaded loop settings
	typedef struct packed {
		word_t      freq_cnt;   // Cycles per half
		word_t      amp_h;
		word_t      amp_l;
		logic       polarity;   // 1 negates the error
		word_t      wait_cnt;   // Cycles skipped at half start
		word_t      err_offset;
		word_t      const_step;
		logic       fb_on;
		logic [4:0] gain_sel;   // Arithmetic shift of the error
		logic       run;
	} fog_cfg_t;

	// Short default period with a small settling wait
	localparam fog_cfg_t CFG_RESET = '{
		freq_cnt:   32'sd8,
		amp_h:      32'sd0,
		amp_l:      32'sd0,
		polarity:   1'b0,
		wait_cnt:   32'sd2,
		err_offset: 32'sd0,
		const_step: 32'sd0,
		fb_on:      1'b0,
		gain_sel:   5'd0,
		run:        1'b0
	};

endpackage

/* design/fog_regs.sv */
`timescale 1ns/10ps

module fog_regs (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_wr_en,     // One write per high cycle
	input  fog_pkg::fog_reg_e i_wr_addr,
	input  fog_pkg::word_t    i_wr_data,
	output fog_pkg::fog_cfg_t o_cfg        // Visible the cycle after the write
);
	import fog_pkg::*;

	// Register bank stand-in for the CPU side
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_cfg <= CFG_RESET;
		end else if (i_wr_en) begin
			case (i_wr_addr)
				REG_FREQ_CNT: begin
					o_cfg.freq_cnt <= i_wr_data;
				end
				REG_AMP_H: begin
					o_cfg.amp_h <= i_wr_data;
				end
				REG_AMP_L: begin
					o_cfg.amp_l <= i_wr_data;
				end
				REG_POLARITY: begin
					o_cfg.polarity <= i_wr_data[0];   // Flag bit only
				end
				REG_WAIT_CNT: begin
					o_cfg.wait_cnt <= i_wr_data;
				end
				REG_ERR_OFFSET: begin
					o_cfg.err_offset <= i_wr_data;
				end
				REG_CONST_STEP: begin
					o_cfg.const_step <= i_wr_data;
				end
				REG_FB_ON: begin
					o_cfg.fb_on <= i_wr_data[0];      // Flag bit only
				end
				REG_GAIN_SEL: begin
					o_cfg.gain_sel <= i_wr_data[4:0]; // Shift 0..31
				end
				REG_RUN: begin
					o_cfg.run <= i_wr_data[0];        // Starts modulation next cycle
				end
				default: begin
					o_cfg <= o_cfg;                   // Undefined index, nothing loads
				end
			endcase
		end
	end

	// Host side must only address defined registers
	a_wr_addr_legal: assert property (
		@(posedge i_clk) disable iff (i_rst)
		i_wr_en |-> (!$isunknown(i_wr_addr) && (i_wr_addr <= REG_RUN))
	) else $error("fog_regs: write to undefined index %0d", i_wr_addr);

endmodule

/* design/fog_mod_gen.sv */
`timescale 1ns/10ps

module fog_mod_gen (
	input  logic              i_clk,
	input  logic              i_rst,
	input  fog_pkg::fog_cfg_t i_cfg,
	output logic              o_half_start, // First cycle of each half
	output fog_pkg::half_e    o_half,       // Valid every cycle
	output fog_pkg::word_t    o_mod         // Level for the DAC sum
);
	import fog_pkg::*;

	word_t cnt_q;    // Cycle index k within the half
	half_e half_q;   // Half being driven while running
	logic  half_end; // k reached freq_cnt-1

	assign half_end = (cnt_q == i_cfg.freq_cnt - 1);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			cnt_q  <= '0;
			half_q <= HALF_H;
		end else if (!i_cfg.run) begin
			cnt_q  <= '0;       // Park at start of a high half
			half_q <= HALF_H;
		end else if (half_end) begin
			cnt_q  <= '0;
			half_q <= (half_q == HALF_H) ? HALF_L : HALF_H; // Toggle level
		end else begin
			cnt_q <= cnt_q + 1;
		end
	end

	// Stopped generator shows HALF_H right away
	assign o_half       = i_cfg.run ? half_q : HALF_H;
	assign o_half_start = i_cfg.run && (cnt_q == '0); // First run cycle starts HALF_H
	assign o_mod        = (o_half == HALF_H) ? i_cfg.amp_h : i_cfg.amp_l;

	// Period must leave room for at least one integrated sample
	a_period_sane: assert property (
		@(posedge i_clk) disable iff (i_rst)
		i_cfg.run |-> ((i_cfg.freq_cnt >= 2) && (i_cfg.freq_cnt > i_cfg.wait_cnt))
	) else $error("fog_mod_gen: freq_cnt %0d too short for wait_cnt %0d",
		i_cfg.freq_cnt, i_cfg.wait_cnt);

endmodule

/* design/fog_demod.sv */
`timescale 1ns/10ps

module fog_demod #(
	parameter int ADC_W = fog_pkg::ADC_W_DEF
) (
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  fog_pkg::fog_cfg_t       i_cfg,
	input  logic                    i_half_start, // Restarts index and sum
	input  fog_pkg::half_e          i_half,
	input  logic signed [ADC_W-1:0] i_adc,
	output fog_pkg::word_t          o_err,
	output logic                    o_err_vld     // One cycle after each low half
);
	import fog_pkg::*;

	word_t k_q;      // Index carried into this cycle
	word_t k_cur;    // Index k of this cycle
	word_t adc_ext;  // Sample widened to a word
	word_t acc_q;    // Running sum of the current half
	word_t acc_nxt;  // Sum including this cycle
	word_t sum_h_q;  // Finished high-half sum
	word_t diff;     // sum_H minus sum_L
	logic  in_win;   // Past the settling wait
	logic  last_cyc; // Final cycle of a half
	logic  end_h;
	logic  end_l;

	assign k_cur    = i_half_start ? '0 : k_q;
	assign in_win   = i_cfg.run && (k_cur >= i_cfg.wait_cnt);
	assign last_cyc = i_cfg.run && (k_cur == i_cfg.freq_cnt - 1);
	assign end_h    = last_cyc && (i_half == HALF_H);
	assign end_l    = last_cyc && (i_half == HALF_L);

	assign adc_ext = word_t'(i_adc); // Sign extension
	assign acc_nxt = (i_half_start ? '0 : acc_q) + (in_win ? adc_ext : '0);
	assign diff    = sum_h_q - acc_nxt; // acc_nxt is the complete low sum at end_l

	// Control path and error output
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			k_q       <= '0;
			o_err_vld <= 1'b0;
			o_err     <= '0;
		end else begin
			k_q       <= i_cfg.run ? (k_cur + 1) : '0; // Idle index held at 0
			o_err_vld <= end_l;
			if (end_l) begin
				o_err <= (i_cfg.polarity ? -diff : diff) + i_cfg.err_offset;
			end
		end
	end

	// Half sums
	always_ff @(posedge i_clk) begin
		acc_q <= acc_nxt;
		if (end_h) begin
			sum_h_q <= acc_nxt; // Held through the low half
		end
	end

	// Error strobe is a single-cycle pulse
	a_err_vld_pulse: assert property (
		@(posedge i_clk) disable iff (i_rst)
		o_err_vld |=> !o_err_vld
	) else $error("fog_demod: err_vld held for two cycles");

endmodule

/* design/fog_loop.sv */
`timescale 1ns/10ps

module fog_loop #(
	parameter int DAC_W = fog_pkg::DAC_W_DEF
) (
	input  logic              i_clk,
	input  logic              i_rst,
	input  fog_pkg::fog_cfg_t i_cfg,
	input  fog_pkg::word_t    i_mod,     // Current modulation level
	input  fog_pkg::word_t    i_err,
	input  logic              i_err_vld, // Update strobe
	output fog_pkg::word_t    o_step,    // Feedback step
	output logic [DAC_W-1:0]  o_dac      // Registered DAC code
);
	import fog_pkg::*;

	word_t err_scaled; // Error after gain shift
	word_t step_nxt;   // Step for this update
	word_t ramp_q;     // Phase ramp, wraps at 32 bits
	word_t dac_sum;    // Ramp plus modulation before truncation

	// Arithmetic shift keeps the error sign
	assign err_scaled = i_err >>> i_cfg.gain_sel;

	// Closed loop integrates the error, open loop takes the fixed step
	assign step_nxt = i_cfg.fb_on ? (o_step + err_scaled) : i_cfg.const_step;

	assign dac_sum = ramp_q + i_mod;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_step <= '0;
			ramp_q <= '0;
			o_dac  <= '0;
		end else begin
			if (i_err_vld) begin
				o_step <= step_nxt;
				ramp_q <= ramp_q + step_nxt; // Ramp takes the new step
			end
			o_dac <= dac_sum[DAC_W-1:0]; // One cycle behind mod
		end
	end

endmodule

/* design/fog_axis.sv */
`timescale 1ns/10ps

module fog_axis #(
	parameter int ADC_W = fog_pkg::ADC_W_DEF,
	parameter int DAC_W = fog_pkg::DAC_W_DEF
) (
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  logic                    i_wr_en,   // Settings write strobe
	input  fog_pkg::fog_reg_e       i_wr_addr,
	input  fog_pkg::word_t          i_wr_data,
	input  logic signed [ADC_W-1:0] i_adc,     // Detector samples
	output fog_pkg::word_t          o_err,
	output logic                    o_err_vld,
	output fog_pkg::word_t          o_step,
	output logic [DAC_W-1:0]        o_dac      // Phase modulator drive
);
	import fog_pkg::*;

	fog_cfg_t cfg;        // Shared settings
	logic     half_start; // Start of each modulation half
	half_e    half;
	word_t    mod;        // Square-wave level

	fog_regs fog_regs_i (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_wr_en   (i_wr_en),
		.i_wr_addr (i_wr_addr),
		.i_wr_data (i_wr_data),
		.o_cfg     (cfg)
	);

	fog_mod_gen fog_mod_gen_i (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_cfg        (cfg),
		.o_half_start (half_start),
		.o_half       (half),
		.o_mod        (mod)
	);

	fog_demod #(
		.ADC_W (ADC_W)
	) fog_demod_i (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_cfg        (cfg),
		.i_half_start (half_start),
		.i_half       (half),
		.i_adc        (i_adc),
		.o_err        (o_err),
		.o_err_vld    (o_err_vld)
	);

	fog_loop #(
		.DAC_W (DAC_W)
	) fog_loop_i (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_cfg     (cfg),
		.i_mod     (mod),
		.i_err     (o_err),
		.i_err_vld (o_err_vld),
		.o_step    (o_step),
		.o_dac     (o_dac)
	);

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen (
	input  logic i_rst_req, // Restarts the reset pulse
	output logic o_clk,
	output logic o_rst
);
	int unsigned rst_cnt; // Reset cycles still to go

	initial begin
		o_clk   = 1'b0;
		rst_cnt = 4;      // Power-on reset
	end

	always #2 o_clk = ~o_clk; // 4 ns period

	always @(posedge o_clk) begin
		if (i_rst_req) begin
			rst_cnt <= 4;
		end else if (rst_cnt != 0) begin
			rst_cnt <= rst_cnt - 1;
		end
	end

	assign o_rst = (rst_cnt != 0);

endmodule

/* tb/tb_fog_axis.sv */
`timescale 1ns/10ps

module tb_fog_axis;
	import fog_pkg::*;

	localparam int ADC_W    = ADC_W_DEF;
	localparam int DAC_W    = DAC_W_DEF;
	localparam int MAX_FREQ = 20;
	// 48 periods of up to 2*MAX_FREQ cycles, reset and writes per test, idle and hold time
	localparam int TEST_CYCLES = 48 * 2 * MAX_FREQ + 6 * 24 + 20 + 15;
	localparam int CYC_LIMIT   = 2 * TEST_CYCLES;

	logic                    clk;
	logic                    rst;
	logic                    rst_req;
	logic                    wr_en;
	fog_reg_e                wr_addr;
	word_t                   wr_data;
	logic signed [ADC_W-1:0] adc;
	word_t                   err;
	logic                    err_vld;
	word_t                   step;
	logic [DAC_W-1:0]        dac;

	// Reference model state, as seen after the last rising edge
	fog_cfg_t         m_cfg;
	int               m_k;     // Cycle index in the current half
	half_e            m_half;
	word_t            m_sum;   // Running half sum
	word_t            m_sum_h; // Sum of the last high half
	word_t            m_err;
	logic             m_vld;
	word_t            m_step;
	word_t            m_ramp;
	logic [DAC_W-1:0] m_dac;

	integer seed;
	int     errs;
	int     errs_at_start;
	int     n_pass;
	int     n_fail;
	int     cyc;
	logic   hold_on;   // Run cleared, loop must sit still
	word_t  hold_step;

	tb_clk_gen tb_clk_gen_i (
		.i_rst_req (rst_req),
		.o_clk     (clk),
		.o_rst     (rst)
	);

	fog_axis #(
		.ADC_W (ADC_W),
		.DAC_W (DAC_W)
	) fog_axis_i (
		.i_clk     (clk),
		.i_rst     (rst),
		.i_wr_en   (wr_en),
		.i_wr_addr (wr_addr),
		.i_wr_data (wr_data),
		.i_adc     (adc),
		.o_err     (err),
		.o_err_vld (err_vld),
		.o_step    (step),
		.o_dac     (dac)
	);

	task automatic reset_model();
		m_cfg          = '0;
		m_cfg.freq_cnt = 8;  // Reset period
		m_cfg.wait_cnt = 2;
		m_k            = 0;
		m_half         = HALF_H;
		m_vld          = 1'b0;
		m_err          = '0;
		m_step         = '0;
		m_ramp         = '0;
		m_dac          = '0;
	endtask

	// Compare mid-cycle, then predict what the next rising edge loads
	always @(negedge clk) begin : model
		word_t            mod_lvl;
		word_t            diff;
		logic             vld_n;
		logic [DAC_W-1:0] dac_n;
		assert (dac == m_dac) else begin
			$display("ERR o_dac got %h exp %h", dac, m_dac);
			errs++;
		end
		assert (err_vld == m_vld) else begin
			$display("ERR o_err_vld got %h exp %h", err_vld, m_vld);
			errs++;
		end
		assert (err == m_err) else begin
			$display("ERR o_err got %h exp %h", err, m_err);
			errs++;
		end
		assert (step == m_step) else begin
			$display("ERR o_step got %h exp %h", step, m_step);
			errs++;
		end
		assert (!hold_on || (!err_vld && step == hold_step)) else begin
			$display("Loop moved or pulsed an error while run was cleared");
			errs++;
		end
		if (rst) begin
			reset_model();
		end else begin
			mod_lvl = (m_cfg.run && m_half == HALF_L) ? m_cfg.amp_l : m_cfg.amp_h;
			dac_n   = DAC_W'(m_ramp + mod_lvl); // Registered one cycle late
			if (m_vld) begin
				m_step = m_cfg.fb_on ? (m_step + (m_err >>> m_cfg.gain_sel)) : m_cfg.const_step;
				m_ramp = m_ramp + m_step;
			end
			vld_n = 1'b0;
			if (m_cfg.run) begin
				if (m_k == 0)
					m_sum = '0;
				if (m_k >= m_cfg.wait_cnt)
					m_sum = m_sum + adc; // Past the settling wait
				if (m_k == m_cfg.freq_cnt - 1) begin
					if (m_half == HALF_H) begin
						m_sum_h = m_sum;
					end else begin
						vld_n = 1'b1;
						diff  = m_sum_h - m_sum;
						m_err = (m_cfg.polarity ? -diff : diff) + m_cfg.err_offset;
					end
					m_k    = 0;
					m_half = (m_half == HALF_H) ? HALF_L : HALF_H;
				end else begin
					m_k = m_k + 1;
				end
			end else begin
				m_k    = 0;      // Stopped, parked at the start of a high half
				m_half = HALF_H;
			end
			m_vld = vld_n;
			m_dac = dac_n;
			if (wr_en) begin
				case (wr_addr)
					REG_FREQ_CNT:   m_cfg.freq_cnt   = wr_data;
					REG_AMP_H:      m_cfg.amp_h      = wr_data;
					REG_AMP_L:      m_cfg.amp_l      = wr_data;
					REG_POLARITY:   m_cfg.polarity   = wr_data[0];
					REG_WAIT_CNT:   m_cfg.wait_cnt   = wr_data;
					REG_ERR_OFFSET: m_cfg.err_offset = wr_data;
					REG_CONST_STEP: m_cfg.const_step = wr_data;
					REG_FB_ON:      m_cfg.fb_on      = wr_data[0];
					REG_GAIN_SEL:   m_cfg.gain_sel   = wr_data[4:0];
					REG_RUN:        m_cfg.run        = wr_data[0];
					default:        m_cfg            = m_cfg;
				endcase
			end
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= CYC_LIMIT) begin
			$display("Timeout after %0d cycles, the DUT stopped making error pulses", cyc);
			$display("Result: FAILED");
			$finish;
		end
	end

	// One clock edge, fresh ADC sample, strobes back low
	task automatic tick();
		@(posedge clk);
		adc     <= $random(seed);
		wr_en   <= 1'b0;
		rst_req <= 1'b0;
	endtask

	task automatic reset_dut();
		tick();
		rst_req <= 1'b1;
		repeat (5) tick();
	endtask

	task automatic write_reg(input fog_reg_e addr, input word_t data);
		tick();
		wr_en   <= 1'b1;
		wr_addr <= addr;
		wr_data <= data;
	endtask

	task automatic config_axis(input bit rnd_demod, input bit rnd_step, input bit fb);
		word_t freq;
		freq = 4 + ($unsigned($random(seed)) % (MAX_FREQ - 3));
		write_reg(REG_FREQ_CNT, freq);
		write_reg(REG_AMP_H, $random(seed));
		write_reg(REG_AMP_L, $random(seed));
		write_reg(REG_WAIT_CNT, rnd_demod ? ($unsigned($random(seed)) % freq) : 2);
		write_reg(REG_POLARITY, rnd_demod ? ($random(seed) & 1) : 0);
		write_reg(REG_ERR_OFFSET, rnd_demod ? $random(seed) : 0);
		write_reg(REG_CONST_STEP, rnd_step ? $random(seed) : 0);
		write_reg(REG_FB_ON, fb);
		write_reg(REG_GAIN_SEL, fb ? ($unsigned($random(seed)) % 13) : 0);
		write_reg(REG_RUN, 1);  // Modulation starts after all settings
	endtask

	task automatic wait_pulses(input int n);
		int got;
		got = 0;
		while (got < n) begin
			tick();
			if (err_vld)
				got++;
		end
	endtask

	task automatic end_test(input string name);
		if (errs == errs_at_start) begin
			n_pass++;
			$display("Test %s: ok", name);
		end else begin
			n_fail++;
			$display("Test %s: %0d mismatches", name, errs - errs_at_start);
		end
		errs_at_start = errs;
	endtask

	initial begin
		seed      = 32'h759c_549e;
		rst_req   = 1'b0;
		wr_en     = 1'b0;
		wr_addr   = REG_FREQ_CNT;
		wr_data   = '0;
		adc       = '0;
		hold_on   = 1'b0;
		hold_step = '0;
		m_sum     = '0;
		m_sum_h   = '0;
		errs      = 0;
		n_pass    = 0;
		n_fail    = 0;
		cyc       = 0;
		reset_model();
		errs_at_start = 0;

		reset_dut();
		repeat (20) tick();
		end_test("reset state");

		reset_dut();
		config_axis(0, 0, 0);
		wait_pulses(8);
		end_test("modulation");

		reset_dut();
		config_axis(1, 0, 0);
		wait_pulses(10);
		end_test("demodulation");

		reset_dut();
		config_axis(1, 1, 0);
		wait_pulses(10);
		end_test("open-loop ramp");

		reset_dut();
		config_axis(1, 0, 1);
		wait_pulses(10);
		end_test("closed loop");

		reset_dut();
		config_axis(1, 1, 1);
		wait_pulses(3);
		write_reg(REG_RUN, 0);
		repeat (3) tick();      // Last pending update lands here
		hold_on   <= 1'b1;
		hold_step <= m_step;
		repeat (11) tick();
		hold_on <= 1'b0;
		write_reg(REG_RUN, 1);
		wait_pulses(7);
		end_test("run toggle");

		$display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* sim.f */
design/fog_pkg.sv
design/fog_regs.sv
design/fog_mod_gen.sv
design/fog_demod.sv
design/fog_loop.sv
design/fog_axis.sv
tb/tb_clk_gen.sv
tb/tb_fog_axis.sv

/* Bender.yml */
package:
  name: fog_axis

sources:
  - files:
      - design/fog_pkg.sv
      - design/fog_regs.sv
      - design/fog_mod_gen.sv
      - design/fog_demod.sv
      - design/fog_loop.sv
      - design/fog_axis.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_fog_axis.sv
